// File: pipe_pkg.sv
// Opcode map is fixed at 4 bits; codes 10..15 decode as NOP and register 0 is not hardwired
`default_nettype none

package pipe_pkg;

    // Register index, 16 architectural registers
    typedef logic [3:0] reg_idx_t;

    // Opcode map, anything not listed is a NOP
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_LDI  = 4'h4,  // rd <= imm8
        OP_LDS  = 4'h5,  // rd <= mem[dseg + rs]
        OP_STS  = 4'h6,  // mem[dseg + rs] <= rd
        OP_BR   = 4'h7,  // Low byte is the offset
        OP_CALL = 4'h8,
        OP_RET  = 4'h9
    } opcode_e;

    // Three-register format
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
    } r_fmt_t;

    // Immediate format, LDI value or BR/CALL offset
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        logic [7:0] imm;
    } i_fmt_t;

    // Same 16-bit word, two views; opcode sits in the top nibble of both
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_word_u;

    // Decoded instruction, 20 bits
    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic     reads_rs;
        logic     reads_rt;
        logic     reads_rd;   // STS store data
        logic     uses_dseg;  // Implicit data-segment base
        logic     writes_rd;
        logic     is_branch;
        logic     is_call;
        logic     is_ret;
    } dec_t;

    // One pending destination behind IF/ID
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
    } dest_t;

endpackage

`default_nettype wire

// File: inst_decode.sv
// Pure combinational decode of the IF/ID word; unknown opcodes give all flags low
`default_nettype none

module inst_decode (
    input  pipe_pkg::inst_word_u inst,
    output pipe_pkg::dec_t       dec
);

    import pipe_pkg::*;

    opcode_e opcode;

    assign opcode = inst.r.opcode;  // Same bits in either view

    always_comb begin
        // Default is r-format fields with no flags, which is also the NOP case
        dec           = '0;
        dec.rd        = inst.r.rd;
        dec.rs        = inst.r.rs;
        dec.rt        = inst.r.rt;

        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                dec.reads_rs  = 1'b1;
                dec.reads_rt  = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OP_LDI: begin
                // rs/rt bits hold the immediate in i-format
                dec.rs        = '0;
                dec.rt        = '0;
                dec.writes_rd = 1'b1;
            end
            OP_LDS: begin
                dec.uses_dseg = 1'b1;  // Base comes from DSEG_REG
                dec.writes_rd = 1'b1;
            end
            OP_STS: begin
                dec.uses_dseg = 1'b1;
                dec.reads_rd  = 1'b1;  // rd carries store data
            end
            OP_BR: begin
                dec.rs        = '0;    // Offset byte, not a register
                dec.rt        = '0;
                dec.is_branch = 1'b1;
            end
            OP_CALL: begin
                dec.rs        = '0;
                dec.rt        = '0;
                dec.is_call   = 1'b1;
            end
            OP_RET: begin
                dec.is_ret    = 1'b1;
            end
            default: begin
                // Flags stay low so a NOP never stalls
                dec.rs        = '0;
                dec.rt        = '0;
                dec.rd        = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: dest_tracker.sv
// Assumes no back-pressure below ID/EX so every stage advances each cycle and bubbles enter on stall
`default_nettype none

module dest_tracker #(
    parameter int unsigned TRACK_DEPTH = 3
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   issue,
    input  pipe_pkg::dec_t                         dec,
    output pipe_pkg::dest_t [TRACK_DEPTH-1:0]      pending
);

    import pipe_pkg::*;

    dest_t entry_in;  // What enters stage 0 this cycle

    // Real entry only when the instruction actually leaves IF/ID
    always_comb begin
        entry_in.valid = issue & dec.writes_rd;
        entry_in.rd    = dec.rd;
    end

    // Valid bits clear on reset while register numbers just shift
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TRACK_DEPTH; i++) begin
                pending[i].valid <= 1'b0;
            end
        end else begin
            pending[0].valid <= entry_in.valid;
            for (int i = 1; i < TRACK_DEPTH; i++) begin
                pending[i].valid <= pending[i-1].valid;  // EX -> MEM -> WB
            end
        end
        pending[0].rd <= entry_in.rd;  // Register number follows its valid bit
        for (int i = 1; i < TRACK_DEPTH; i++) begin
            pending[i].rd <= pending[i-1].rd;
        end
    end

endmodule

`default_nettype wire

// File: hazard_unit.sv
// Stall-only hazard control, no forwarding; halt after CALL/RET lasts until fetch pulses pc_update
`default_nettype none

module hazard_unit #(
    parameter int unsigned TRACK_DEPTH = 3,
    parameter int unsigned DSEG_REG    = 14
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   inst_valid,
    input  logic                                   pc_update,
    input  pipe_pkg::dec_t                         dec,
    input  pipe_pkg::dest_t [TRACK_DEPTH-1:0]      pending,
    output logic                                   data_hazard,
    output logic                                   pc_hazard,
    output logic                                   issue
);

    import pipe_pkg::*;

    localparam reg_idx_t DSEG_IDX = reg_idx_t'(DSEG_REG);

    reg_idx_t src_a;     // rs, or the data-segment register for LDS/STS
    logic     src_a_en;
    logic     is_ctrl;   // BR, CALL, RET
    logic     raw_match;
    logic     halt_q;    // Waiting for redirected PC

    assign is_ctrl  = dec.is_branch | dec.is_call | dec.is_ret;
    assign src_a    = dec.uses_dseg ? DSEG_IDX : dec.rs;
    assign src_a_en = dec.reads_rs | dec.uses_dseg;

    // Every source against every pending write
    always_comb begin
        raw_match = 1'b0;
        for (int i = 0; i < TRACK_DEPTH; i++) begin
            if (pending[i].valid) begin
                if (src_a_en && (pending[i].rd == src_a)) begin
                    raw_match = 1'b1;
                end
                if (dec.reads_rt && (pending[i].rd == dec.rt)) begin
                    raw_match = 1'b1;
                end
                if (dec.reads_rd && (pending[i].rd == dec.rd)) begin
                    raw_match = 1'b1;  // STS data operand
                end
            end
        end
    end

    // Control flow skips the data check entirely
    assign data_hazard = inst_valid & ~is_ctrl & raw_match;

    // pc_update releases the halt in its own cycle
    assign pc_hazard   = halt_q & ~pc_update;

    assign issue       = inst_valid & ~data_hazard & ~pc_hazard;

    // Halt flag
    always_ff @(posedge clk) begin
        if (rst) begin
            halt_q <= 1'b0;
        end else if (issue && (dec.is_call || dec.is_ret)) begin
            halt_q <= 1'b1;  // Wins over a pc_update in the same cycle
        end else if (pc_update) begin
            halt_q <= 1'b0;  // Stray pulse with no halt is harmless
        end
    end

endmodule

`default_nettype wire

// File: issue_ctrl_top.sv
// Issue-control slice only; register file, ALU, memory and fetch live outside and see issue as the stall
`default_nettype none

module issue_ctrl_top #(
    parameter int unsigned TRACK_DEPTH = 3,   // Stages behind IF/ID that still write
    parameter int unsigned DSEG_REG    = 14   // Implicit base for LDS/STS
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inst_valid,
    input  pipe_pkg::inst_word_u inst,
    input  logic                 pc_update,
    output logic                 issue,
    output logic                 data_hazard,
    output logic                 pc_hazard
);

    import pipe_pkg::*;

    dec_t                    dec;
    dest_t [TRACK_DEPTH-1:0] pending;  // Index 0 is ID/EX

    inst_decode u_inst_decode (
        .inst (inst),
        .dec  (dec)
    );

    dest_tracker #(
        .TRACK_DEPTH (TRACK_DEPTH)
    ) u_dest_tracker (
        .clk     (clk),
        .rst     (rst),
        .issue   (issue),
        .dec     (dec),
        .pending (pending)
    );

    hazard_unit #(
        .TRACK_DEPTH (TRACK_DEPTH),
        .DSEG_REG    (DSEG_REG)
    ) u_hazard_unit (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .pc_update   (pc_update),
        .dec         (dec),
        .pending     (pending),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard),
        .issue       (issue)
    );

endmodule

`default_nettype wire

// File: issue_ctrl_sva.sv
// Bound into every hazard_unit instance; properties are off while rst is high
`default_nettype none

module issue_ctrl_sva (
    input logic           clk,
    input logic           rst,
    input logic           issue,
    input logic           pc_update,
    input logic           pc_hazard,
    input logic           raw_match,
    input pipe_pkg::dec_t dec
);

    // No issue right after a CALL/RET until fetch reloads the PC
    a_no_issue_in_halt: assert property (@(posedge clk) disable iff (rst)
        (issue && (dec.is_call || dec.is_ret)) |=> (!issue || pc_update))
        else $error("issue right after CALL/RET without pc_update");

    // Halt flag starts clear
    a_pc_clear_after_rst: assert property (@(posedge clk)
        $fell(rst) |-> !pc_hazard) else $error("pc_hazard high right after reset");

    // Control flow brings no source register into the data check
    a_ctrl_no_data: assert property (@(posedge clk) disable iff (rst)
        (dec.is_branch || dec.is_call || dec.is_ret) |-> !raw_match)
        else $error("control-flow instruction matched a pending destination");

endmodule

bind hazard_unit issue_ctrl_sva u_issue_ctrl_sva (
    .clk         (clk),
    .rst         (rst),
    .issue       (issue),
    .pc_update   (pc_update),
    .pc_hazard   (pc_hazard),
    .raw_match   (raw_match),
    .dec         (dec)
);

`default_nettype wire

// File: issue_monitor.sv
// Compares DUT outputs against model values on falling edges; reset cycles are not compared
`default_nettype none

module issue_monitor (
    input  logic clk,
    input  logic rst,
    input  logic test_end,
    input  int   test_num,
    input  logic all_done,
    input  logic issue,
    input  logic data_hazard,
    input  logic pc_hazard,
    input  logic exp_issue,
    input  logic exp_data,
    input  logic exp_pc,
    output int   mism_total
);

    int  test_mism = 0;
    int  compared  = 0;
    int  tests     = 0;
    bit  reported  = 0;

    initial mism_total = 0;

    task automatic compare_bit(input string name, input logic dut, input logic exp);
        if (dut !== exp) begin
            $display("mismatch at %0t: %s dut=%b model=%b", $time, name, dut, exp);
            test_mism++;
            mism_total++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            compare_bit("issue", issue, exp_issue);
            compare_bit("data_hazard", data_hazard, exp_data);
            compare_bit("pc_hazard", pc_hazard, exp_pc);
            compared++;
        end
        // One line per finished test
        if (test_end) begin
            $display("Test %0d finished with %0d mismatches", test_num, test_mism);
            test_mism = 0;
            tests++;
        end
        if (all_done && !reported) begin
            $display("Tests %0d, compared cycles %0d, mismatches %0d",
                     tests, compared, mism_total);
            reported = 1;
        end
    end

endmodule

`default_nettype wire

// File: tb_issue_ctrl.sv
// Model assumes TRACK_DEPTH 3 and DSEG_REG 14; inputs change on rising edges, checks on falling
`default_nettype none

module tb_issue_ctrl;

    import pipe_pkg::*;

    localparam int TD        = 3;
    localparam int DSEG      = 14;
    localparam int RAND_LEN  = 2000;
    localparam int CYC_LIMIT = 8 + 250 + RAND_LEN + 300;  // Reset, directed, random, margin

    logic        clk = 1'b0;
    logic        rst;
    logic        inst_valid;
    logic [15:0] inst;
    logic        pc_update;
    logic        issue, data_hazard, pc_hazard;
    logic        exp_issue, exp_data, exp_pc;
    logic        test_end, all_done;
    int          test_num, mism_total, dir_err, cycles;
    logic [31:0] lfsr = 32'h86b5_fcc0;

    // Reference model state
    logic [TD-1:0]       m_valid;
    logic [TD-1:0][3:0]  m_rd;
    logic                m_halt;
    logic [3:0]          op, f_rd, f_rs, f_rt;
    logic                rd_rs, rd_rt, rd_rd, dseg, wr, ctrl, match;

    always #50 clk = ~clk;  // Period 100

    issue_ctrl_top #(.TRACK_DEPTH(TD), .DSEG_REG(DSEG)) u_issue_ctrl_top (
        .clk (clk), .rst (rst), .inst_valid (inst_valid), .inst (inst),
        .pc_update (pc_update), .issue (issue), .data_hazard (data_hazard),
        .pc_hazard (pc_hazard)
    );

    issue_monitor u_issue_monitor (
        .clk (clk), .rst (rst), .test_end (test_end), .test_num (test_num),
        .all_done (all_done), .issue (issue), .data_hazard (data_hazard),
        .pc_hazard (pc_hazard), .exp_issue (exp_issue), .exp_data (exp_data),
        .exp_pc (exp_pc), .mism_total (mism_total)
    );

    // Opcode table written out from the instruction rules
    always_comb begin
        op    = inst[15:12];
        f_rd  = inst[11:8];
        f_rs  = inst[7:4];
        f_rt  = inst[3:0];
        rd_rs = (op <= 4'd3);              // ALU ops
        rd_rt = (op <= 4'd3);
        rd_rd = (op == 4'd6);              // STS store data
        dseg  = (op == 4'd5) || (op == 4'd6);
        wr    = (op <= 4'd5);              // ALU, LDI and LDS
        ctrl  = (op == 4'd7) || (op == 4'd8) || (op == 4'd9);
        match = 1'b0;
        for (int i = 0; i < TD; i++) begin
            if (m_valid[i] && ((rd_rs && m_rd[i] == f_rs) || (rd_rt && m_rd[i] == f_rt)
                || (rd_rd && m_rd[i] == f_rd) || (dseg && m_rd[i] == 4'(DSEG)))) begin
                match = 1'b1;
            end
        end
        exp_data  = inst_valid & ~ctrl & match;
        exp_pc    = m_halt & ~pc_update;
        exp_issue = inst_valid & ~exp_data & ~exp_pc;
    end

    always @(posedge clk) begin
        if (rst) begin
            m_valid <= '0;
            m_halt  <= 1'b0;
        end else begin
            m_valid <= {m_valid[TD-2:0], exp_issue & wr};
            m_rd    <= {m_rd[TD-2:0], f_rd};
            if (exp_issue && (op == 4'd8 || op == 4'd9)) m_halt <= 1'b1;
            else if (pc_update) m_halt <= 1'b0;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYC_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic drive_inst(input logic v, input logic [15:0] w, input logic p);
        @(posedge clk);
        inst_valid <= v;
        inst       <= w;
        pc_update  <= p;
    endtask

    // Falling edges with issue low until it rises
    task automatic expect_stalls(input int want);
        int n;
        n = 0;
        @(negedge clk);
        while (!issue && n < 20) begin
            n++;
            @(negedge clk);
        end
        if (n != want) begin
            $display("Test %0d: expected %0d stall cycles but saw %0d", test_num, want, n);
            dir_err++;
        end
    endtask

    task automatic expect_issue(input logic want);
        @(negedge clk);
        if (issue !== want) begin
            $display("Test %0d: issue was %b at %0t, expected %b", test_num, issue, $time, want);
            dir_err++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_inst(1'b0, 16'hf000, 1'b0);
    endtask

    task automatic finish_test;
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        test_num <= test_num + 1;
    endtask

    // Consumer waits TRACK_DEPTH cycles behind its producer
    task automatic raw_pair(input logic [15:0] prod, input logic [15:0] cons, input int want);
        drive_inst(1'b1, prod, 1'b0);
        expect_stalls(0);
        drive_inst(1'b1, cons, 1'b0);
        expect_stalls(want);
        idle_cycles(TD + 1);
    endtask

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = 16'hf000;
        pc_update  = 1'b0;
        test_end   = 1'b0;
        all_done   = 1'b0;
        test_num   = 1;
        dir_err    = 0;
        cycles     = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // Test 1 checks reset state and a free instruction
        idle_cycles(3);
        drive_inst(1'b1, 16'h4312, 1'b0);   // LDI r3
        expect_stalls(0);
        idle_cycles(TD + 1);
        finish_test();
        // Test 2 RAW on rs, rt and STS data
        raw_pair(16'h0512, 16'h1653, TD);   // ADD r5 then SUB reads r5 as rs
        raw_pair(16'h0712, 16'h2817, TD);   // rt dependency
        raw_pair(16'h3912, 16'h6900, TD);   // STS stores r9
        finish_test();
        // Test 3 data segment base
        raw_pair(16'h4e00, 16'h5100, TD);   // LDI r14 then LDS
        raw_pair(16'h4700, 16'h5170, 0);    // Match on rs field alone does not stall
        raw_pair(16'h4e00, 16'h6270, TD);   // STS after r14
        finish_test();
        // Test 4 CALL, RET and BR
        drive_inst(1'b1, 16'h8005, 1'b0);
        expect_stalls(0);
        repeat (3) begin
            drive_inst(1'b1, 16'h0123, 1'b0);
            expect_issue(1'b0);
        end
        drive_inst(1'b1, 16'h0123, 1'b1);   // Released in the pulse cycle
        expect_issue(1'b1);
        drive_inst(1'b1, 16'h9000, 1'b0);   // RET
        expect_stalls(0);
        drive_inst(1'b1, 16'h4200, 1'b0);
        expect_issue(1'b0);
        drive_inst(1'b1, 16'h4200, 1'b1);
        expect_issue(1'b1);
        drive_inst(1'b1, 16'h0b34, 1'b0);   // Writes r11 from r3 and r4
        expect_stalls(0);
        drive_inst(1'b1, 16'h7bbb, 1'b0);   // BR with r11 in its bits
        expect_stalls(0);
        idle_cycles(TD + 1);
        finish_test();
        // Test 5 random stream
        for (int k = 0; k < RAND_LEN; k++) begin
            drive_inst(take_bits(2) != 0, take_bits(16), take_bits(3) == 7);
        end
        idle_cycles(2);
        finish_test();
        @(posedge clk);
        all_done <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        if (mism_total == 0 && dir_err == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
pipe_pkg.sv
inst_decode.sv
dest_tracker.sv
hazard_unit.sv
issue_ctrl_top.sv
issue_ctrl_sva.sv
issue_monitor.sv
tb_issue_ctrl.sv

// File: Bender.yml
package:
  name: issue_ctrl

sources:
  - pipe_pkg.sv
  - inst_decode.sv
  - dest_tracker.sv
  - hazard_unit.sv
  - issue_ctrl_top.sv
  - target: simulation
    files:
      - issue_ctrl_sva.sv
      - issue_monitor.sv
      - tb_issue_ctrl.sv
